//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

	// Pixel coordinate wide enough for any common VGA mode
	typedef logic [10:0] coord_t;

	// RGB332 colour with red in [7:5], green in [4:2] and blue in [1:0]
	typedef logic [7:0] rgb_t;

	// Number of prizes still on the map
	typedef logic [7:0] count_t;

	// Contents of one map cell
	typedef enum logic [2:0] {
		PRIZE_NONE = 3'd0,
		PRIZE_COIN = 3'd1,
		PRIZE_GEM  = 3'd2,
		PRIZE_STAR = 3'd3
	} prize_t;

	localparam rgb_t COLOR_BG     = 8'h00;
	localparam rgb_t COLOR_PLAYER = 8'hFF;

	// Base prize colours whose bit 0 is replaced by the shade bit
	localparam rgb_t COIN_COLOR = 8'hFC;
	localparam rgb_t GEM_COLOR  = 8'h1F;
	localparam rgb_t STAR_COLOR = 8'hE3;

endpackage

`default_nettype wire

//--- src/vga_scan.sv
`timescale 1ns/1ps
`default_nettype none

module vga_scan #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic            clk,
	input  logic            resetN,
	output game_pkg::coord_t pixel_x,
	output game_pkg::coord_t pixel_y,
	output logic            active,
	output logic            frame_start,
	output logic            hsync,
	output logic            vsync,
	output logic            blank
);
	import game_pkg::*;

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam coord_t LAST_X       = coord_t'(H_TOTAL - 1);
	localparam coord_t LAST_Y       = coord_t'(V_TOTAL - 1);
	localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + H_FRONT);
	localparam coord_t H_SYNC_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + V_FRONT);
	localparam coord_t V_SYNC_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

	logic       hsync_now;
	logic       vsync_now;
	logic [1:0] hsync_pipe;
	logic [1:0] vsync_pipe;
	logic [1:0] blank_pipe;

	// ####################
	// Pixel and line counters
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			pixel_x <= '0;
			pixel_y <= '0;
		end
		else if (pixel_x == LAST_X)
		begin
			pixel_x <= '0;
			pixel_y <= (pixel_y == LAST_Y) ? '0 : pixel_y + coord_t'(1);
		end
		else
		begin
			pixel_x <= pixel_x + coord_t'(1);
		end
	end

	assign active      = (pixel_x < coord_t'(H_ACTIVE)) && (pixel_y < coord_t'(V_ACTIVE));
	assign frame_start = (pixel_x == '0) && (pixel_y == '0);

	// Sync pulses are active low
	assign hsync_now = !((pixel_x >= H_SYNC_START) && (pixel_x < H_SYNC_END));
	assign vsync_now = !((pixel_y >= V_SYNC_START) && (pixel_y < V_SYNC_END));

	// ####################
	// Two clocks of delay so sync and blank meet rgb
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			hsync_pipe <= 2'b11;
			vsync_pipe <= 2'b11;
			blank_pipe <= 2'b11;
		end
		else
		begin
			hsync_pipe <= {hsync_pipe[0], hsync_now};
			vsync_pipe <= {vsync_pipe[0], vsync_now};
			blank_pipe <= {blank_pipe[0], !active};
		end
	end

	assign hsync = hsync_pipe[1];
	assign vsync = vsync_pipe[1];
	assign blank = blank_pipe[1];

	a_x_in_line: assert property (@(posedge clk) disable iff (!resetN)
		pixel_x < coord_t'(H_TOTAL));

endmodule

`default_nettype wire

//--- src/prize_map.sv
`timescale 1ns/1ps
`default_nettype none

module prize_map #(
	parameter int TILE_SHIFT  = 6,
	parameter int NUM_ROWS    = 7,
	parameter int NUM_COLS    = 10,
	parameter int PLAYER_SIZE = 16
) (
	input  logic             clk,
	input  logic             resetN,
	input  game_pkg::coord_t pixel_x,
	input  game_pkg::coord_t pixel_y,
	input  logic             active,
	input  game_pkg::coord_t player_x,
	input  game_pkg::coord_t player_y,
	input  logic [9:0]       random_bits,
	input  logic             collision,
	output logic             prize_draw,
	output game_pkg::rgb_t   prize_color,
	output logic             prize_taken,
	output game_pkg::count_t prizes_left
);
	import game_pkg::*;

	localparam int ROW_W = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
	localparam int COL_W = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

	// Initial contents put prizes on the even checkerboard squares
	function automatic prize_t rule_cell(input int r, input int c);
		if (((r + c) % 2) != 0)
			return PRIZE_NONE;
		case ((r * NUM_COLS + c) % 3)
			0:       return PRIZE_COIN;
			1:       return PRIZE_GEM;
			default: return PRIZE_STAR;
		endcase
	endfunction

	function automatic int rule_count();
		int n;
		n = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			for (int c = 0; c < NUM_COLS; c++)
				if (rule_cell(r, c) != PRIZE_NONE)
					n++;
		return n;
	endfunction

	localparam count_t INIT_COUNT = count_t'(rule_count());

	prize_t grid [NUM_ROWS][NUM_COLS];

	coord_t           tile_x, tile_y;
	coord_t           centre_x, centre_y;
	coord_t           centre_col, centre_row;
	logic             pix_in_grid, centre_in_grid;
	prize_t           pix_cell, centre_cell;
	logic [3:0]       shade_idx;
	rgb_t             base_color;
	logic             take_now;

	// ####################
	// Lookup of the prize under the current pixel
	assign tile_x      = pixel_x >> TILE_SHIFT;
	assign tile_y      = pixel_y >> TILE_SHIFT;
	assign pix_in_grid = (tile_x < coord_t'(NUM_COLS)) && (tile_y < coord_t'(NUM_ROWS));
	assign pix_cell    = pix_in_grid ? grid[tile_y[ROW_W-1:0]][tile_x[COL_W-1:0]] : PRIZE_NONE;
	assign shade_idx   = 4'((tile_x ^ tile_y) % 10);

	always_comb
	begin
		case (pix_cell)
			PRIZE_COIN: base_color = COIN_COLOR;
			PRIZE_GEM:  base_color = GEM_COLOR;
			PRIZE_STAR: base_color = STAR_COLOR;
			default:    base_color = COLOR_BG;
		endcase
	end

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
			prize_draw <= 1'b0;
		else
			prize_draw <= active && (pix_cell != PRIZE_NONE);
	end

	always_ff @(posedge clk)
	begin
		if (pix_cell == PRIZE_NONE)
			prize_color <= COLOR_BG;
		else
			prize_color <= {base_color[7:1], random_bits[shade_idx]};
	end

	// ####################
	// Collection of the prize under the player's centre
	assign centre_x       = player_x + coord_t'(PLAYER_SIZE / 2);
	assign centre_y       = player_y + coord_t'(PLAYER_SIZE / 2);
	assign centre_col     = centre_x >> TILE_SHIFT;
	assign centre_row     = centre_y >> TILE_SHIFT;
	assign centre_in_grid = (centre_col < coord_t'(NUM_COLS)) &&
	                        (centre_row < coord_t'(NUM_ROWS));
	assign centre_cell    = centre_in_grid ?
	                        grid[centre_row[ROW_W-1:0]][centre_col[COL_W-1:0]] : PRIZE_NONE;
	assign take_now       = collision && (centre_cell != PRIZE_NONE);

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			for (int r = 0; r < NUM_ROWS; r++)
				for (int c = 0; c < NUM_COLS; c++)
					grid[r][c] <= rule_cell(r, c);
			prize_taken <= 1'b0;
			prizes_left <= INIT_COUNT;
		end
		else
		begin
			prize_taken <= take_now;
			if (take_now)
			begin
				grid[centre_row[ROW_W-1:0]][centre_col[COL_W-1:0]] <= PRIZE_NONE;
				prizes_left <= prizes_left - count_t'(1);
			end
		end
	end

	// A prize can only be taken while the count still holds it
	a_no_wrap: assert property (@(posedge clk) disable iff (!resetN)
		take_now |-> prizes_left != '0);

endmodule

`default_nettype wire

//--- src/player_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module player_sprite #(
	parameter int H_ACTIVE    = 640,
	parameter int V_ACTIVE    = 480,
	parameter int TILE_SHIFT  = 6,
	parameter int PLAYER_SIZE = 16,
	parameter int PLAYER_STEP = 4
) (
	input  logic             clk,
	input  logic             resetN,
	input  game_pkg::coord_t pixel_x,
	input  game_pkg::coord_t pixel_y,
	input  logic             active,
	input  logic             frame_start,
	input  logic             move_left,
	input  logic             move_right,
	input  logic             move_up,
	input  logic             move_down,
	output game_pkg::coord_t player_x,
	output game_pkg::coord_t player_y,
	output logic             player_draw
);
	import game_pkg::*;

	localparam coord_t STEP  = coord_t'(PLAYER_STEP);
	localparam coord_t SIZE  = coord_t'(PLAYER_SIZE);
	localparam coord_t X_MAX = coord_t'(H_ACTIVE - PLAYER_SIZE);
	localparam coord_t Y_MAX = coord_t'(V_ACTIVE - PLAYER_SIZE);

	// Start on tile (0,1) because the map leaves it free
	localparam coord_t START_X = coord_t'(1 << TILE_SHIFT);

	coord_t next_x;
	coord_t next_y;

	// ####################
	// Next position clamped to the visible area
	always_comb
	begin
		next_x = player_x;
		next_y = player_y;
		if (move_left)
			next_x = (next_x >= STEP) ? next_x - STEP : '0;
		if (move_right)
			next_x = (next_x + STEP <= X_MAX) ? next_x + STEP : X_MAX;
		if (move_up)
			next_y = (next_y >= STEP) ? next_y - STEP : '0;
		if (move_down)
			next_y = (next_y + STEP <= Y_MAX) ? next_y + STEP : Y_MAX;
	end

	// Position only moves between frames so a frame never tears
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
		begin
			player_x <= START_X;
			player_y <= '0;
		end
		else if (frame_start)
		begin
			player_x <= next_x;
			player_y <= next_y;
		end
	end

	// ####################
	// Is the current pixel inside the square
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
			player_draw <= 1'b0;
		else
			player_draw <= active &&
			               (pixel_x >= player_x) && (pixel_x < player_x + SIZE) &&
			               (pixel_y >= player_y) && (pixel_y < player_y + SIZE);
	end

	a_in_clamp: assert property (@(posedge clk) disable iff (!resetN)
		(player_x <= X_MAX) && (player_y <= Y_MAX));

endmodule

`default_nettype wire

//--- src/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
	input  logic           clk,
	input  logic           resetN,
	input  logic           prize_draw,
	input  game_pkg::rgb_t prize_color,
	input  logic           player_draw,
	output game_pkg::rgb_t rgb,
	output logic           collision
);
	import game_pkg::*;

	rgb_t mixed;

	// ####################
	// The player wins over the prize and the prize over the background
	always_comb
	begin
		if (player_draw)
			mixed = COLOR_PLAYER;
		else if (prize_draw)
			mixed = prize_color;
		else
			mixed = COLOR_BG;
	end

	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
			rgb <= COLOR_BG;
		else
			rgb <= mixed;
	end

	// Overlap of the player with a prize is a collision
	always_ff @(posedge clk or negedge resetN)
	begin
		if (!resetN)
			collision <= 1'b0;
		else
			collision <= player_draw && prize_draw;
	end

endmodule

`default_nettype wire

//--- src/prize_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module prize_game_top #(
	parameter int H_ACTIVE    = 640,
	parameter int H_FRONT     = 16,
	parameter int H_SYNC      = 96,
	parameter int H_BACK      = 48,
	parameter int V_ACTIVE    = 480,
	parameter int V_FRONT     = 10,
	parameter int V_SYNC      = 2,
	parameter int V_BACK      = 33,
	parameter int TILE_SHIFT  = 6,
	parameter int NUM_ROWS    = 7,
	parameter int NUM_COLS    = 10,
	parameter int PLAYER_SIZE = 16,
	parameter int PLAYER_STEP = 4
) (
	input  logic             clk,
	input  logic             resetN,
	input  logic             move_left,
	input  logic             move_right,
	input  logic             move_up,
	input  logic             move_down,
	input  logic [9:0]       random_bits,
	output logic             hsync,
	output logic             vsync,
	output logic             blank,
	output game_pkg::rgb_t   rgb,
	output logic             prize_taken,
	output logic             prize_taken_raw,
	output game_pkg::count_t prizes_left
);
	import game_pkg::*;

	coord_t pixel_x, pixel_y;
	coord_t player_x, player_y;
	logic   active, frame_start;
	logic   prize_draw, player_draw;
	rgb_t   prize_color;

	vga_scan #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_scan (
		.clk(clk), .resetN(resetN),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .active(active), .frame_start(frame_start),
		.hsync(hsync), .vsync(vsync), .blank(blank)
	);

	prize_map #(
		.TILE_SHIFT(TILE_SHIFT), .NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS),
		.PLAYER_SIZE(PLAYER_SIZE)
	) u_map (
		.clk(clk), .resetN(resetN),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .active(active),
		.player_x(player_x), .player_y(player_y),
		.random_bits(random_bits), .collision(prize_taken_raw),
		.prize_draw(prize_draw), .prize_color(prize_color),
		.prize_taken(prize_taken), .prizes_left(prizes_left)
	);

	player_sprite #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .TILE_SHIFT(TILE_SHIFT),
		.PLAYER_SIZE(PLAYER_SIZE), .PLAYER_STEP(PLAYER_STEP)
	) u_player (
		.clk(clk), .resetN(resetN),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .active(active), .frame_start(frame_start),
		.move_left(move_left), .move_right(move_right),
		.move_up(move_up), .move_down(move_down),
		.player_x(player_x), .player_y(player_y), .player_draw(player_draw)
	);

	// The collision pulse also leaves the chip for debug
	pixel_mixer u_mixer (
		.clk(clk), .resetN(resetN),
		.prize_draw(prize_draw), .prize_color(prize_color), .player_draw(player_draw),
		.rgb(rgb), .collision(prize_taken_raw)
	);

endmodule

`default_nettype wire

//--- tb/prize_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module prize_game_tb;
	import game_pkg::*;

	localparam int H_ACTIVE    = 128;
	localparam int H_FRONT     = 4;
	localparam int H_SYNC      = 8;
	localparam int H_BACK      = 4;
	localparam int V_ACTIVE    = 64;
	localparam int V_FRONT     = 2;
	localparam int V_SYNC      = 2;
	localparam int V_BACK      = 2;
	localparam int TILE_SHIFT  = 4;
	localparam int NUM_ROWS    = 4;
	localparam int NUM_COLS    = 8;
	localparam int PLAYER_SIZE = 4;
	localparam int PLAYER_STEP = 4;

	localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
	localparam int X_MAX      = H_ACTIVE - PLAYER_SIZE;
	localparam int Y_MAX      = V_ACTIVE - PLAYER_SIZE;

	logic       clk;
	logic       resetN;
	logic       move_left, move_right, move_up, move_down;
	logic [9:0] random_bits;
	logic       hsync, vsync, blank;
	rgb_t       rgb;
	logic       prize_taken;
	logic       prize_taken_raw;
	count_t     prizes_left;

	// Reference copy of the map holding 0 for empty, 1 for coin, 2 for gem and 3 for star
	int cell_model [NUM_ROWS][NUM_COLS];
	int left_model;
	int px, py;
	int rand_bits;
	int box_x, box_y, box_n;
	int frame_takes;
	int errors, checks, tests_run, tests_failed;
	bit timed_out;

	prize_game_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.TILE_SHIFT(TILE_SHIFT), .NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS),
		.PLAYER_SIZE(PLAYER_SIZE), .PLAYER_STEP(PLAYER_STEP)
	) dut (
		.clk(clk), .resetN(resetN),
		.move_left(move_left), .move_right(move_right),
		.move_up(move_up), .move_down(move_down), .random_bits(random_bits),
		.hsync(hsync), .vsync(vsync), .blank(blank), .rgb(rgb),
		.prize_taken(prize_taken), .prize_taken_raw(prize_taken_raw),
		.prizes_left(prizes_left)
	);

	always #20 clk = ~clk;

	// ####################
	// Checking and reporting
	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("Test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - err_start);
		end
	endtask

	// ####################
	// Reference model of map, player and picture
	task automatic init_model();
		left_model = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			for (int c = 0; c < NUM_COLS; c++)
			begin
				cell_model[r][c] = 0;
				if ((r + c) % 2 == 0)
				begin
					cell_model[r][c] = (r * NUM_COLS + c) % 3 + 1;
					left_model++;
				end
			end
		px = 1 << TILE_SHIFT;
		py = 0;
	endtask

	task automatic move_model();
		if (move_left)
			px = (px >= PLAYER_STEP) ? px - PLAYER_STEP : 0;
		if (move_right)
			px = (px + PLAYER_STEP <= X_MAX) ? px + PLAYER_STEP : X_MAX;
		if (move_up)
			py = (py >= PLAYER_STEP) ? py - PLAYER_STEP : 0;
		if (move_down)
			py = (py + PLAYER_STEP <= Y_MAX) ? py + PLAYER_STEP : Y_MAX;
	endtask

	function automatic logic [7:0] expected_rgb(input int x, input int y);
		int         r;
		int         c;
		int         shade;
		logic [7:0] base;
		if (x >= H_ACTIVE || y >= V_ACTIVE)
			return COLOR_BG;
		if (x >= px && x < px + PLAYER_SIZE && y >= py && y < py + PLAYER_SIZE)
			return COLOR_PLAYER;
		r = y >> TILE_SHIFT;
		c = x >> TILE_SHIFT;
		case (cell_model[r][c])
			1:       base = COIN_COLOR;
			2:       base = GEM_COLOR;
			3:       base = STAR_COLOR;
			default: return COLOR_BG;
		endcase
		shade = (rand_bits >> ((c ^ r) % 10)) & 1;
		return {base[7:1], shade[0]};
	endfunction

	// Waits for the next falling edge of hsync or vsync and counts hsync edges on the way
	task automatic wait_fall(input bit use_vsync, input int limit, output int clocks,
	                         output int hs_falls);
		logic prev_v;
		logic prev_h;
		bit   seen;
		clocks = 0;
		hs_falls = 0;
		seen = 1'b0;
		prev_v = vsync;
		prev_h = hsync;
		while (!seen && clocks < limit)
		begin
			@(negedge clk);
			clocks++;
			if (prev_h && !hsync)
				hs_falls++;
			seen = use_vsync ? (prev_v && !vsync) : (prev_h && !hsync);
			prev_v = vsync;
			prev_h = hsync;
		end
		if (!seen)
		begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: %s did not fall within %0d clocks",
			         use_vsync ? "vsync" : "hsync", limit);
		end
	endtask

	// Runs one frame from the vsync falling edge
	// The first sample there is output pixel (0, V_ACTIVE+V_FRONT)
	task automatic run_frame(input bit check_pixels);
		int   i;
		int   x;
		int   y;
		int   cr;
		int   cc;
		int   exp_takes;
		int   raw_count;
		bit   pixel_check;
		logic prev_raw;
		move_model();
		cr = (py + PLAYER_SIZE / 2) >> TILE_SHIFT;
		cc = (px + PLAYER_SIZE / 2) >> TILE_SHIFT;
		exp_takes = (cell_model[cr][cc] != 0) ? 1 : 0;
		// The map changes part way through a frame that takes a prize
		pixel_check = check_pixels && (exp_takes == 0);
		x = 0;
		y = V_ACTIVE + V_FRONT;
		frame_takes = 0;
		raw_count = 0;
		prev_raw = 1'b0;
		box_x = H_ACTIVE;
		box_y = V_ACTIVE;
		box_n = 0;
		for (i = 0; i < FRAME_CLKS; i++)
		begin
			if (rgb == COLOR_PLAYER)
			begin
				box_n++;
				if (x < box_x)
					box_x = x;
				if (y < box_y)
					box_y = y;
			end
			// A taken prize always follows a collision by one clock
			if (prize_taken)
			begin
				frame_takes++;
				check_value("prize_taken_raw before prize_taken", 32'(prev_raw), 1);
			end
			if (prize_taken_raw)
				raw_count++;
			prev_raw = prize_taken_raw;
			if (pixel_check)
			begin
				check_value($sformatf("rgb(%0d,%0d)", x, y), 32'(rgb),
				            32'(expected_rgb(x, y)));
				check_value($sformatf("blank(%0d,%0d)", x, y), 32'(blank),
				            (x >= H_ACTIVE || y >= V_ACTIVE) ? 1 : 0);
			end
			@(negedge clk);
			x++;
			if (x == H_TOTAL)
			begin
				x = 0;
				y = (y == V_TOTAL - 1) ? 0 : y + 1;
			end
		end
		check_value("prize_taken pulses in frame", frame_takes, exp_takes);
		check_value("prize_taken_raw seen in frame", (raw_count != 0) ? 1 : 0, exp_takes);
		if (exp_takes != 0)
		begin
			cell_model[cr][cc] = 0;
			left_model--;
		end
		check_value("prizes_left", 32'(prizes_left), left_model);
		check_value("player left edge", box_x, px);
		check_value("player top edge", box_y, py);
		check_value("player pixel count", box_n, PLAYER_SIZE * PLAYER_SIZE);
	endtask

	// ####################
	// Directed tests
	task automatic test_reset();
		int err_start;
		err_start = errors;
		repeat (2) @(negedge clk);
		check_value("hsync", 32'(hsync), 1);
		check_value("vsync", 32'(vsync), 1);
		check_value("blank", 32'(blank), 1);
		check_value("rgb", 32'(rgb), 32'(COLOR_BG));
		check_value("prize_taken", 32'(prize_taken), 0);
		check_value("prize_taken_raw", 32'(prize_taken_raw), 0);
		check_value("prizes_left", 32'(prizes_left), left_model);
		@(negedge clk);
		resetN = 1'b1;
		report_test("reset state", err_start);
	endtask

	task automatic test_scan_timing();
		int err_start;
		int clocks;
		int hs_falls;
		if (timed_out)
			return;
		err_start = errors;
		wait_fall(1'b0, 2 * H_TOTAL, clocks, hs_falls);
		if (!timed_out)
			wait_fall(1'b0, 2 * H_TOTAL, clocks, hs_falls);
		if (!timed_out)
			check_value("clocks per line", clocks, H_TOTAL);
		if (!timed_out)
			wait_fall(1'b1, 2 * FRAME_CLKS, clocks, hs_falls);
		if (!timed_out)
			wait_fall(1'b1, 2 * FRAME_CLKS, clocks, hs_falls);
		if (!timed_out)
			check_value("lines per frame", hs_falls, V_TOTAL);
		report_test("scan timing", err_start);
	endtask

	task automatic test_prize_drawing();
		int err_start;
		int clocks;
		int hs_falls;
		if (timed_out)
			return;
		err_start = errors;
		wait_fall(1'b1, 2 * FRAME_CLKS, clocks, hs_falls);
		if (!timed_out)
			run_frame(1'b1);
		report_test("prize drawing", err_start);
	endtask

	task automatic test_movement();
		int err_start;
		int start_x;
		int start_y;
		if (timed_out)
			return;
		err_start = errors;
		start_x = px;
		start_y = py;
		move_right = 1'b1;
		repeat (3) run_frame(1'b0);
		move_right = 1'b0;
		check_value("player x after 3 frames", box_x, start_x + 3 * PLAYER_STEP);
		check_value("player y after 3 frames", box_y, start_y);
		// Held long enough to run into the right edge
		move_right = 1'b1;
		repeat (30) run_frame(1'b0);
		move_right = 1'b0;
		check_value("player x at clamp", box_x, X_MAX);
		report_test("player movement", err_start);
	endtask

	task automatic test_collection();
		int err_start;
		int left_before;
		int frames;
		int total_takes;
		if (timed_out)
			return;
		err_start = errors;
		rand_bits = int'($urandom() & 32'h3FF);
		random_bits = 10'(rand_bits);
		left_before = int'(prizes_left);
		total_takes = 0;
		frames = 0;
		// Walk down the right edge until the centre lands on a prize
		move_down = 1'b1;
		while (total_takes == 0 && frames < 2 * V_ACTIVE / PLAYER_STEP)
		begin
			run_frame(1'b0);
			total_takes += frame_takes;
			frames++;
		end
		move_down = 1'b0;
		check_value("prize_taken pulses on arrival", total_takes, 1);
		check_value("prizes_left after collection", 32'(prizes_left), left_before - 1);
		// Emptied tile must now draw as background
		run_frame(1'b1);
		report_test("collection", err_start);
	endtask

	task automatic test_no_double_count();
		int err_start;
		int left_before;
		int total_takes;
		if (timed_out)
			return;
		err_start = errors;
		left_before = int'(prizes_left);
		total_takes = 0;
		repeat (3)
		begin
			run_frame(1'b1);
			total_takes += frame_takes;
		end
		check_value("prize_taken pulses while parked", total_takes, 0);
		check_value("prizes_left while parked", 32'(prizes_left), left_before);
		report_test("no double count", err_start);
	endtask

	initial
	begin
		clk = 1'b0;
		resetN = 1'b0;
		move_left = 1'b0;
		move_right = 1'b0;
		move_up = 1'b0;
		move_down = 1'b0;
		random_bits = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		void'($urandom(39));
		init_model();
		rand_bits = int'($urandom() & 32'h3FF);
		random_bits = 10'(rand_bits);

		test_reset();
		test_scan_timing();
		test_prize_drawing();
		test_movement();
		test_collection();
		test_no_double_count();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
src/game_pkg.sv
src/vga_scan.sv
src/prize_map.sv
src/player_sprite.sv
src/pixel_mixer.sv
src/prize_game_top.sv
tb/prize_game_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module prize_game_tb \
	-f list.f -o prize_game_sim || { echo "Build failed"; exit 1; }
./obj_dir/prize_game_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0
